/* project.f */
source/enc_pkg.sv
source/enc_input_sync.sv
source/enc_quad_decoder.sv
source/enc_period_timer.sv
source/enc_host_port.sv
source/enc_top.sv
tb/enc_clock_gen.sv
tb/enc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module enc_tb -o enc_sim
./obj_dir/enc_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

/* tb/enc_tb.sv */
// Encoder interface testbench

`timescale 1ns/1ps

module enc_tb;
    import enc_pkg::*;

    localparam int walk_holds = 400;    // pin changes per walk
    localparam int max_hold   = 20;     // longest hold, 4 + 16
    localparam int max_cycles = 2 * (2 * walk_holds * max_hold) + 8000;    // two walks plus reads

    logic                      clk;
    logic                      reset;
    logic [num_channels-1:0]   enc_a;
    logic [num_channels-1:0]   enc_b;
    logic                      wr_en;
    logic [chan_sel_width-1:0] wr_channel;
    logic [count_width-1:0]    wr_data;
    logic                      rd_en;
    logic [chan_sel_width-1:0] rd_channel;
    logic [1:0]                rd_select;
    logic                      rd_valid;
    logic [data_width-1:0]     rd_data;

    integer seed = 32'hfa02c8d4;

    // reference model, one entry per channel
    logic [count_width:0]    exp_count  [num_channels];     // {overflow, counter}
    logic                    exp_dir    [num_channels];
    logic                    exp_err    [num_channels];
    logic [period_width-1:0] exp_period [num_channels];
    int                      last_step  [num_channels];     // cycle of the last legal pin change
    int                      cycle;
    int                      checks;
    int                      errors;

    enc_clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    enc_top DUT (
        .clk        (clk),
        .reset      (reset),
        .enc_a      (enc_a),
        .enc_b      (enc_b),
        .wr_en      (wr_en),
        .wr_channel (wr_channel),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_channel (rd_channel),
        .rd_select  (rd_select),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

    // ------------------------------------------------------------
    // cycle count and run limit
    // ------------------------------------------------------------
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles)
        begin
            $display("timeout: run went past %0d cycles without finishing", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic tick(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #2;     // inputs change just after the edge
        end
    endtask

    // one legal Gray-code step, pins and model together
    task automatic move(input int ch, input logic up);
        logic [count_width-1:0] cnt;
        int                     gap;
        cnt = exp_count[ch][count_width-1:0];
        if (up == (enc_a[ch] == enc_b[ch]))     // up: 00 10 11 01, down the reverse
            enc_a[ch] = ~enc_a[ch];
        else
            enc_b[ch] = ~enc_b[ch];
        if (up)
        begin
            if (cnt == {count_width{1'b1}})
                exp_count[ch][count_width] = 1'b1;  // wraps to zero
            exp_count[ch][count_width-1:0] = cnt + 1'b1;
        end
        else
        begin
            if (cnt == '0)
                exp_count[ch][count_width] = 1'b1;  // wraps to all ones
            exp_count[ch][count_width-1:0] = cnt - 1'b1;
        end
        exp_dir[ch] = up;
        gap = cycle - last_step[ch];
        exp_period[ch] = (gap >= 65535) ? '1 : period_width'(gap);
        last_step[ch] = cycle;
    endtask

    // random walk on all channels, idle channels allowed or not
    task automatic walk(input int holds, input logic allow_idle);
        logic [31:0] r;
        for (int i = 0; i < holds; i++)
        begin
            for (int ch = 0; ch < num_channels; ch++)
            begin
                r = $random(seed);
                if (!allow_idle || r[1:0] != 2'b00)
                    move(ch, r[2]);
            end
            r = $random(seed);
            tick(4 + int'(r % 17));     // hold 4 to 20 cycles
        end
        tick(4);
    endtask

    task automatic preload(input int ch, input logic [count_width-1:0] value);
        wr_en      = 1'b1;
        wr_channel = chan_sel_width'(ch);
        wr_data    = value;
        exp_count[ch] = {1'b0, value};  // flags cleared
        exp_err[ch]   = 1'b0;
        tick(1);
        wr_en = 1'b0;
        tick(3);                        // two cycle load latency plus slack
    endtask

    // rd_valid must come exactly one cycle after rd_en and last one cycle
    task automatic host_read(input int ch, input logic [1:0] sel,
                             output logic [data_width-1:0] data);
        rd_en      = 1'b1;
        rd_channel = chan_sel_width'(ch);
        rd_select  = sel;
        tick(1);
        rd_en = 1'b0;
        checks++;
        if (rd_valid !== 1'b1)
        begin
            $display("[FAIL] rd_valid ch%0d after rd_en: got %h, expected 1", ch, rd_valid);
            errors++;
        end
        data = rd_data;
        tick(1);
        checks++;
        if (rd_valid !== 1'b0)
        begin
            $display("[FAIL] rd_valid ch%0d one cycle later: got %h, expected 0",
                     ch, rd_valid);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // read back one channel and compare with the model
    // ------------------------------------------------------------
    task automatic check_channel(input int ch);
        logic [data_width-1:0] got;
        logic [data_width-1:0] status;
        status = '0;
        status[status_dir_bit] = exp_dir[ch];
        status[status_ovf_bit] = exp_count[ch][count_width];
        status[status_err_bit] = exp_err[ch];
        host_read(ch, sel_count, got);
        checks++;
        if (got !== data_width'(exp_count[ch]))
        begin
            $display("[FAIL] count ch%0d: got %h, expected %h",
                     ch, got, data_width'(exp_count[ch]));
            errors++;
        end
        host_read(ch, sel_status, got);
        checks++;
        if (got !== status)
        begin
            $display("[FAIL] status ch%0d: got %h, expected %h", ch, got, status);
            errors++;
        end
        host_read(ch, sel_period, got);
        checks++;
        if (got !== data_width'(exp_period[ch]))
        begin
            $display("[FAIL] period ch%0d: got %h, expected %h",
                     ch, got, data_width'(exp_period[ch]));
            errors++;
        end
    endtask

    task automatic check_all();
        for (int ch = 0; ch < num_channels; ch++)
            check_channel(ch);
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errs_before);
    endtask

    initial
    begin
        int          mark;
        int          ch;
        logic [31:0] r;
        checks     = 0;
        errors     = 0;
        enc_a      = '0;
        enc_b      = '0;
        wr_en      = 1'b0;
        wr_channel = '0;
        wr_data    = '0;
        rd_en      = 1'b0;
        rd_channel = '0;
        rd_select  = '0;
        for (int i = 0; i < num_channels; i++)
        begin
            exp_count[i]  = {1'b0, enc_midrange};
            exp_dir[i]    = 1'b0;
            exp_err[i]    = 1'b0;
            exp_period[i] = '1;             // nothing measured yet
            last_step[i]  = -70000;         // first step reads as saturated
        end
        @(negedge reset);
        tick(1);

        mark = errors;
        check_all();
        report("test 1 reset values", mark);

        mark = errors;
        walk(walk_holds, 1'b1);
        check_all();
        report("test 2 random walk", mark);

        mark = errors;
        repeat (4)
        begin
            r  = $random(seed);
            ch = int'(r[1:0]);
            preload(ch, r[31:8]);
            check_all();        // others must be untouched
        end
        report("test 3 preload", mark);

        mark = errors;
        r  = $random(seed);
        ch = int'(r[1:0]);
        enc_a[ch] = ~enc_a[ch];     // both lines at once
        enc_b[ch] = ~enc_b[ch];
        exp_err[ch] = 1'b1;
        tick(6);
        check_all();
        preload(ch, r[31:8]);
        check_all();
        report("test 4 illegal transition", mark);

        mark = errors;
        r  = $random(seed);
        ch = int'(r[1:0]);
        preload(ch, '1);
        move(ch, 1'b1);
        tick(6);
        check_all();
        preload(ch, '0);
        move(ch, 1'b0);
        tick(6);
        check_all();
        report("test 5 overflow", mark);

        mark = errors;
        walk(walk_holds, 1'b0);     // every channel steps each hold
        check_all();
        report("test 6 period", mark);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* tb/enc_clock_gen.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module enc_clock_gen (
    output logic clk,
    output logic reset
);
    // 20 ns period
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge clk);     // ten cycles in reset
        #2;
        reset = 1'b0;                   // released off the edge, like the other inputs
    end

endmodule

/* source/enc_top.sv */
// Four-channel quadrature encoder interface

`timescale 1ns/1ps

module enc_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [enc_pkg::num_channels-1:0]      enc_a,        // encoder pins
    input  logic [enc_pkg::num_channels-1:0]      enc_b,
    input  logic                                  wr_en,        // preload strobe
    input  logic [enc_pkg::chan_sel_width-1:0]    wr_channel,
    input  logic [enc_pkg::count_width-1:0]       wr_data,
    input  logic                                  rd_en,        // read strobe
    input  logic [enc_pkg::chan_sel_width-1:0]    rd_channel,
    input  logic [1:0]                            rd_select,
    output logic                                  rd_valid,
    output logic [enc_pkg::data_width-1:0]        rd_data
);
    import enc_pkg::*;

    logic [num_channels-1:0]                 sync_a;
    logic [num_channels-1:0]                 sync_b;
    logic [num_channels-1:0]                 set_enc;
    logic [count_width-1:0]                  preload_value;
    logic [num_channels*(count_width+1)-1:0] count_all;
    logic [num_channels*period_width-1:0]    period_all;
    logic [num_channels-1:0]                 dir_all;
    logic [num_channels-1:0]                 error_all;
    logic [num_channels-1:0]                 step_all;    // decoder to timer

    enc_input_sync u_sync (
        .clk    (clk),
        .reset  (reset),
        .enc_a  (enc_a),
        .enc_b  (enc_b),
        .sync_a (sync_a),
        .sync_b (sync_b)
    );

    // ------------------------------------------------------------
    // one decoder and one timer per channel
    // ------------------------------------------------------------
    for (genvar ch = 0; ch < num_channels; ch++)
    begin : g_chan
        enc_quad_decoder u_dec (
            .clk     (clk),
            .reset   (reset),
            .a       (sync_a[ch]),
            .b       (sync_b[ch]),
            .set_enc (set_enc[ch]),
            .preload (preload_value),       // shared, strobe picks the channel
            .count   (count_all[ch*(count_width+1) +: count_width+1]),
            .dir     (dir_all[ch]),
            .error   (error_all[ch]),
            .step    (step_all[ch])
        );

        enc_period_timer u_timer (
            .clk    (clk),
            .reset  (reset),
            .step   (step_all[ch]),
            .period (period_all[ch*period_width +: period_width])
        );
    end

    enc_host_port u_host (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_channel    (wr_channel),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_channel    (rd_channel),
        .rd_select     (rd_select),
        .count_all     (count_all),
        .period_all    (period_all),
        .dir_all       (dir_all),
        .error_all     (error_all),
        .set_enc       (set_enc),
        .preload_value (preload_value),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

endmodule

/* source/enc_host_port.sv */
// Encoder host port

`timescale 1ns/1ps

module enc_host_port (
    input  logic clk,
    input  logic reset,
    // write side
    input  logic                                  wr_en,
    input  logic [enc_pkg::chan_sel_width-1:0]    wr_channel,
    input  logic [enc_pkg::count_width-1:0]       wr_data,
    // read side
    input  logic                                  rd_en,
    input  logic [enc_pkg::chan_sel_width-1:0]    rd_channel,
    input  logic [1:0]                            rd_select,
    // per-channel state, channel 0 in the low slice
    input  logic [enc_pkg::num_channels*(enc_pkg::count_width+1)-1:0] count_all,
    input  logic [enc_pkg::num_channels*enc_pkg::period_width-1:0]    period_all,
    input  logic [enc_pkg::num_channels-1:0]                          dir_all,
    input  logic [enc_pkg::num_channels-1:0]                          error_all,
    // outputs
    output logic [enc_pkg::num_channels-1:0]      set_enc,        // one-hot preload
    output logic [enc_pkg::count_width-1:0]       preload_value,
    output logic                                  rd_valid,
    output logic [enc_pkg::data_width-1:0]        rd_data
);
    import enc_pkg::*;

    logic [count_width:0]    count_sel;    // {overflow, counter} of rd_channel
    logic [period_width-1:0] period_sel;
    logic [data_width-1:0]   status_word;
    logic [data_width-1:0]   read_word;    // next rd_data

    // ------------------------------------------------------------
    // write path, strobe and data registered together
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            set_enc <= '0;
        else
            set_enc <= wr_en ? (num_channels'(1) << wr_channel) : '0;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            preload_value <= wr_data;   // only sampled when set_enc fires
    end

    // ------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------
    assign count_sel  = count_all[rd_channel*(count_width+1) +: count_width+1];
    assign period_sel = period_all[rd_channel*period_width +: period_width];

    always_comb
    begin
        status_word = '0;
        status_word[status_dir_bit] = dir_all[rd_channel];
        status_word[status_ovf_bit] = count_sel[count_width];   // overflow is the msb
        status_word[status_err_bit] = error_all[rd_channel];

        case (rd_select)
            sel_count:  read_word = {{(data_width-count_width-1){1'b0}}, count_sel};
            sel_period: read_word = {{(data_width-period_width){1'b0}}, period_sel};
            sel_status: read_word = status_word;
            default:    read_word = '0;     // unused code
        endcase
    end

    // one cycle read latency, a same-cycle write shows up later
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end
        else
        begin
            rd_valid <= rd_en;
            if (rd_en)
                rd_data <= read_word;
        end
    end

endmodule

/* source/enc_period_timer.sv */
// Step-to-step period timer

`timescale 1ns/1ps

module enc_period_timer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             step,     // pulse from the decoder
    output logic [enc_pkg::period_width-1:0] period    // clocks between last two steps
);
    import enc_pkg::*;

    logic [period_width-1:0] elapsed;     // clocks since the last step
    logic                    elapsed_max; // counter pinned at its ceiling

    assign elapsed_max = (elapsed == period_saturated);

    // ------------------------------------------------------------
    // running counter, saturates rather than wrapping
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            elapsed <= period_saturated;    // no step seen yet, too slow to tell
        else if (step)
            elapsed <= '0;                  // restart on every step
        else if (!elapsed_max)
            elapsed <= elapsed + 1'b1;
    end

    // ------------------------------------------------------------
    // latch on step
    // ------------------------------------------------------------
    // elapsed lags the step edge by one clock, so the +1 makes the
    // readout equal to the pin-to-pin spacing
    always_ff @(posedge clk)
    begin
        if (reset)
            period <= period_saturated;
        else if (step)
        begin
            if (elapsed_max)
                period <= period_saturated;     // stays pinned, never wraps
            else
                period <= elapsed + 1'b1;
        end
    end

endmodule

/* source/enc_quad_decoder.sv */
// Quadrature decoder and position counter

`timescale 1ns/1ps

module enc_quad_decoder (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             a,          // synchronized line a
    input  logic                             b,          // synchronized line b
    input  logic                             set_enc,    // preload strobe
    input  logic [enc_pkg::count_width-1:0]  preload,    // preload value
    output logic [enc_pkg::count_width:0]    count,      // {overflow, counter}
    output logic                             dir,        // last step direction
    output logic                             error,      // sticky illegal transition
    output logic                             step        // one-cycle pulse per step
);
    import enc_pkg::*;

    logic [1:0]             code;          // current {a, b}
    logic [1:0]             prev;          // code seen at the last edge
    logic                   a_moved;
    logic                   b_moved;
    logic                   one_line;      // legal single-line transition
    logic                   both_lines;    // a and b flipped together
    logic                   step_up;       // direction of this transition
    logic [count_width-1:0] counter;
    logic                   overflow;

    // ------------------------------------------------------------
    // transition classification
    // ------------------------------------------------------------
    assign code       = {a, b};
    assign a_moved    = code[1] ^ prev[1];
    assign b_moved    = code[0] ^ prev[0];
    assign one_line   = a_moved ^ b_moved;      // exactly one line changed
    assign both_lines = a_moved & b_moved;      // skipped a state, no direction
    assign step_up    = code[1] ^ prev[0];      // new a vs old b, 1 is a leading

    assign count = {overflow, counter};         // overflow rides as the msb

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prev <= 2'b00;      // matches the synchronizer reset value
            dir  <= 1'b0;
            step <= 1'b0;
        end
        else
        begin
            prev <= code;
            step <= one_line;   // timer still sees the step during a preload
            if (one_line)
                dir <= step_up;
        end
    end

    // ------------------------------------------------------------
    // position counter and sticky flags, preload has priority
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            counter  <= enc_midrange;
            overflow <= 1'b0;
            error    <= 1'b0;
        end
        else if (set_enc)
        begin
            counter  <= preload;    // host load clears both flags
            overflow <= 1'b0;
            error    <= 1'b0;
        end
        else
        begin
            if (one_line && step_up)
            begin
                counter <= counter + 1'b1;
                if (&counter)
                    overflow <= 1'b1;   // wrapped all ones to zero
            end
            else if (one_line)
            begin
                counter <= counter - 1'b1;
                if (counter == '0)
                    overflow <= 1'b1;   // wrapped zero to all ones
            end

            if (both_lines)
                error <= 1'b1;          // count left alone
        end
    end

endmodule

/* source/enc_input_sync.sv */
// Encoder pin synchronizer

`timescale 1ns/1ps

module enc_input_sync (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [enc_pkg::num_channels-1:0] enc_a,    // raw pins, async to clk
    input  logic [enc_pkg::num_channels-1:0] enc_b,
    output logic [enc_pkg::num_channels-1:0] sync_a,   // safe to decode
    output logic [enc_pkg::num_channels-1:0] sync_b
);
    import enc_pkg::*;

    logic [num_channels-1:0] meta_a;    // first stage, may go metastable
    logic [num_channels-1:0] meta_b;

    // ------------------------------------------------------------
    // two flops per line, all channels in parallel
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            meta_a <= '0;
            meta_b <= '0;
            sync_a <= '0;
            sync_b <= '0;
        end
        else
        begin
            meta_a <= enc_a;        // sample the pins
            meta_b <= enc_b;
            sync_a <= meta_a;       // settled copy for the decoders
            sync_b <= meta_b;
        end
    end

endmodule

/* source/enc_pkg.sv */
// Encoder interface shared constants

package enc_pkg;

    // ------------------------------------------------------------
    // channel and datapath sizes
    // ------------------------------------------------------------
    localparam int num_channels   = 4;     // encoder channels in the block
    localparam int count_width    = 24;    // position counter, overflow bit not included
    localparam int period_width   = 16;    // step-to-step period counter
    localparam int chan_sel_width = 2;     // host channel number
    localparam int data_width     = 32;    // host read word

    // counter value after reset, so a channel can move either way
    localparam logic [count_width-1:0] enc_midrange = 24'h800000;

    // period readout when no step was seen in range
    localparam logic [period_width-1:0] period_saturated = '1;

    // ------------------------------------------------------------
    // host read select codes
    // ------------------------------------------------------------
    localparam logic [1:0] sel_count  = 2'd0;   // {overflow, counter}
    localparam logic [1:0] sel_period = 2'd1;   // last measured period
    localparam logic [1:0] sel_status = 2'd2;   // dir / overflow / error flags
    // code 3 is unused and reads back as zero

    // ------------------------------------------------------------
    // status word layout
    // ------------------------------------------------------------
    localparam int status_dir_bit = 0;     // 1 means a leads b, counting up
    localparam int status_ovf_bit = 1;     // sticky counter wrap
    localparam int status_err_bit = 2;     // sticky illegal transition

endpackage
